/* tests/rv_int_patterns.txt */
# columns: name kind a b c d, all numbers hex, unused fields 0
# dbg_write: a=addr b=data | dbg_read: a=addr b=expected | instr: a=word b=rd c=data d=illegal
w_x1 dbg_write 01 0000000c 0 0
w_x2 dbg_write 02 fffffff0 0 0
w_x3 dbg_write 03 00000007 0 0
w_x0 dbg_write 00 deadbeef 0 0
rd_x1 dbg_read 01 0000000c 0 0
op_add instr 002082b3 05 fffffffc 0
op_sub instr 40208333 06 0000001c 0
op_sll instr 003093b3 07 00000600 0
op_slt instr 00112433 08 00000001 0
op_sltu instr 001134b3 09 00000000 0
op_xor instr 0020c533 0a fffffffc 0
op_srl instr 003155b3 0b 01ffffff 0
op_sra instr 40315633 0c ffffffff 0
op_or instr 0030e6b3 0d 0000000f 0
op_and instr 0030f733 0e 00000004 0
op_addi instr fec08793 0f fffffff8 0
op_slti instr ff112813 10 00000001 0
op_sltiu instr fff0b893 11 00000001 0
op_xori instr 0ff0c913 12 000000f3 0
op_ori instr 00516993 13 fffffff5 0
op_andi instr 7f817a13 14 000007f0 0
op_slli instr 00409a93 15 000000c0 0
op_srli instr 00415b13 16 0fffffff 0
op_srai instr 40415b93 17 ffffffff 0
fwd_addi instr 00108c13 18 0000000d 0
fwd_add instr 018c0cb3 19 0000001a 0
fwd_sub instr 418c8d33 1a 0000000d 0
gap idle 0 0 0 0
sp_addi instr 00108d93 1b 0000000d 0
sp_wait1 idle 0 0 0 0
sp_wait2 idle 0 0 0 0
sp_add instr 01bd8e33 1c 0000001a 0
x0_addi instr 00508013 00 00000011 0
ill_opc instr 0000a283 05 00000000 1
ill_f7 instr 4030f2b3 05 00000000 1
rd_x0 dbg_read 00 00000000 0 0
rd_x5 dbg_read 05 fffffffc 0 0
wb_addi instr 10008f13 1e 0000010c 0
wb_wait idle 0 0 0 0
w_x30 dbg_write 1e 12345678 0 0
rd_x30 dbg_read 1e 0000010c 0 0

/* rv_int_core.f */
+incdir+hw
hw/rv_int_pkg.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_int_core.sv
tests/rv_int_core_checker.sv
tests/rv_int_core_assert.sv
tests/rv_int_core_tb.sv

/* Bender.yml */
package:
  name: rv_int_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_int_pkg.sv
      - hw/rv_regfile.sv
      - hw/rv_decode.sv
      - hw/rv_execute.sv
      - hw/rv_int_core.sv
      - target: test
        files:
          - tests/rv_int_core_checker.sv
          - tests/rv_int_core_assert.sv
          - tests/rv_int_core_tb.sv

/* tests/rv_int_core_tb.sv */
// testbench top for the integer core: clock, reset, pattern-driven stimulus, run limit and summary
`timescale 1ns/1ps
`default_nettype none

`include "rv_int_config.svh"

module rv_int_core_tb;

    localparam int MAX_LINES = 64;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  instr_valid_i;
    logic [`RV_XLEN-1:0]   instr_i;
    logic                  retire_valid_o;
    logic [`RV_REG_AW-1:0] retire_rd_o;
    logic [`RV_XLEN-1:0]   retire_data_o;
    logic                  retire_illegal_o;
    logic                  dbg_we_i;
    logic [`RV_REG_AW-1:0] dbg_addr_i;
    logic [`RV_XLEN-1:0]   dbg_wdata_i;
    logic [`RV_XLEN-1:0]   dbg_rdata_o;
    rv_int_pkg::ex_wb_t    retire_rec;  // retire ports bundled for the checker

    string               pat_name [MAX_LINES];
    string               pat_kind [MAX_LINES];
    logic [`RV_XLEN-1:0] pat_f [MAX_LINES][4];  // field meaning depends on kind
    int                  num_lines = 0;
    int                  cycle_limit = 0;  // zero until patterns are loaded
    int                  cycles = 0;
    int                  total_fail;

    rv_int_core rv_int_core_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .instr_valid_i    (instr_valid_i),
        .instr_i          (instr_i),
        .retire_valid_o   (retire_valid_o),
        .retire_rd_o      (retire_rd_o),
        .retire_data_o    (retire_data_o),
        .retire_illegal_o (retire_illegal_o),
        .dbg_we_i         (dbg_we_i),
        .dbg_addr_i       (dbg_addr_i),
        .dbg_wdata_i      (dbg_wdata_i),
        .dbg_rdata_o      (dbg_rdata_o)
    );

    assign retire_rec = '{valid: retire_valid_o, illegal: retire_illegal_o, rd: retire_rd_o,
                          result: retire_data_o};

    rv_int_core_checker checker_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .retire_i    (retire_rec),
        .dbg_rdata_i (dbg_rdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;  // 8 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $finish;
    endtask

    // wait until every issued instruction has retired, its write lands on the edge we return on
    task automatic wait_retired();
        while (checker_i.pending() != 0) begin
            @(posedge clk_i);
        end
    endtask

    // one pattern per line, '#' lines skipped
    task automatic load_patterns();
        int                  fd;
        string               line;
        string               nm;
        string               kd;
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic [`RV_XLEN-1:0] c;
        logic [`RV_XLEN-1:0] d;
        fd = $fopen("tests/rv_int_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the pattern file");
        end else begin
            while (!$feof(fd) && (num_lines < MAX_LINES)) begin
                line = "";
                void'($fgets(line, fd));
                if ((line.len() > 1) && (line[0] != "#") &&
                    ($sscanf(line, "%s %s %h %h %h %h", nm, kd, a, b, c, d) == 6)) begin
                    pat_name[num_lines] = nm;
                    pat_kind[num_lines] = kd;
                    pat_f[num_lines][0] = a;
                    pat_f[num_lines][1] = b;
                    pat_f[num_lines][2] = c;
                    pat_f[num_lines][3] = d;
                    num_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        dbg_we_i      = 1'b0;
        dbg_addr_i    = '0;
        dbg_wdata_i   = '0;
        load_patterns();
        cycle_limit = 4 * num_lines + 20;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        for (int k = 0; k < num_lines; k++) begin
            @(posedge clk_i);
            instr_valid_i <= 1'b0;  // strobes last one cycle
            dbg_we_i      <= 1'b0;
            if (pat_kind[k] == "dbg_write") begin
                dbg_we_i    <= 1'b1;
                dbg_addr_i  <= pat_f[k][0][`RV_REG_AW-1:0];
                dbg_wdata_i <= pat_f[k][1];
            end else if (pat_kind[k] == "dbg_read") begin
                wait_retired();  // debug view has no bypass
                dbg_addr_i <= pat_f[k][0][`RV_REG_AW-1:0];
                checker_i.check_dbg(pat_name[k], pat_f[k][1]);  // samples on the falling edge
            end else if (pat_kind[k] == "instr") begin
                instr_valid_i <= 1'b1;
                instr_i       <= pat_f[k][0];
                checker_i.expect_retire(pat_name[k],
                    '{valid: 1'b1, illegal: pat_f[k][3][0], rd: pat_f[k][1][`RV_REG_AW-1:0],
                      result: pat_f[k][2]});
            end else if (pat_kind[k] != "idle") begin
                abort_run({"unknown pattern kind ", pat_kind[k]});
            end
        end
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        dbg_we_i      <= 1'b0;
        wait_retired();  // drain the pipeline
        total_fail = checker_i.fail_count + rv_int_core_i.core_assert_i.err_count;
        $display("summary: %0d passed, %0d failed", checker_i.pass_count, total_fail);
        if (total_fail == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // run limit scales with the pattern count
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if ((cycle_limit != 0) && (cycles >= cycle_limit)) begin
            checker_i.report_leftover();
            abort_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
        end
    end

endmodule

`default_nettype wire

/* tests/rv_int_core_assert.sv */
// concurrent checks on retire timing, reset state and the x0 debug view, bound into the core top
`timescale 1ns/1ps
`default_nettype none

`include "rv_int_config.svh"

module rv_int_core_assert (
    input wire logic                  clk_i,
    input wire logic                  rst_n_i,
    input wire logic                  instr_valid_i,
    input wire logic                  retire_valid_i,
    input wire logic                  retire_illegal_i,
    input wire logic [`RV_REG_AW-1:0] dbg_addr_i,
    input wire logic [`RV_XLEN-1:0]   dbg_rdata_i
);

    int err_count = 0;  // folded into the run summary

    // issue to retire is two edges, both ways
    issue_to_retire_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_valid_i |-> ##2 retire_valid_i)
        else begin $error("issue not followed by a retire two cycles later"); err_count++; end

    retire_from_issue_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        retire_valid_i |-> $past(instr_valid_i, 2))
        else begin $error("retire without an issue two cycles earlier"); err_count++; end

    reset_clears_retire_a: assert property (@(posedge clk_i)
        !rst_n_i |=> (!retire_valid_i && !retire_illegal_i))
        else begin $error("retire outputs high after reset"); err_count++; end

    x0_reads_zero_a: assert property (@(posedge clk_i)
        (dbg_addr_i == '0) |-> (dbg_rdata_i == '0))
        else begin $error("debug read of x0 is not zero"); err_count++; end

endmodule

bind rv_int_core rv_int_core_assert core_assert_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .instr_valid_i    (instr_valid_i),
    .retire_valid_i   (retire_valid_o),
    .retire_illegal_i (retire_illegal_o),
    .dbg_addr_i       (dbg_addr_i),
    .dbg_rdata_i      (dbg_rdata_o)
);

`default_nettype wire

/* tests/rv_int_core_checker.sv */
// checker for the integer core: compares retire records and debug reads with queued expectations
`timescale 1ns/1ps
`default_nettype none

`include "rv_int_config.svh"

module rv_int_core_checker (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire rv_int_pkg::ex_wb_t  retire_i,     // retire outputs of the DUT
    input  wire logic [`RV_XLEN-1:0] dbg_rdata_i
);

    rv_int_pkg::ex_wb_t exp_q [$];  // in issue order
    string              name_q [$];
    int                 pass_count = 0;
    int                 fail_count = 0;

    task automatic expect_retire(input string name, input rv_int_pkg::ex_wb_t rec);
        exp_q.push_back(rec);
        name_q.push_back(name);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    // debug view settles within the cycle
    task automatic check_dbg(input string name, input logic [`RV_XLEN-1:0] exp);
        @(negedge clk_i);
        if (dbg_rdata_i === exp) begin
            pass_count++;
            $display("ok     %s", name);
        end else begin
            fail_count++;
            $display("FAILED %s: expected %h, got %h", name, exp, dbg_rdata_i);
        end
    endtask

    task automatic report_leftover();
        while (exp_q.size() != 0) begin
            fail_count++;
            $display("%s was issued but never retired", name_q.pop_front());
            exp_q.delete(0);
        end
    endtask

    task automatic compare_retire(input string name, input rv_int_pkg::ex_wb_t exp);
        if (retire_i === exp) begin
            pass_count++;
            $display("ok     %s", name);
        end else begin
            fail_count++;
            $display("FAILED %s: expected rd x%0d data %h illegal %b, got rd x%0d data %h illegal %b",
                     name, exp.rd, exp.result, exp.illegal,
                     retire_i.rd, retire_i.result, retire_i.illegal);
        end
    endtask

    always @(negedge clk_i) begin
        if (rst_n_i && retire_i.valid) begin
            if (exp_q.size() == 0) begin
                fail_count++;
                $display("a retire of x%0d arrived with no instruction outstanding", retire_i.rd);
            end else begin
                compare_retire(name_q.pop_front(), exp_q.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rv_int_core.sv */
// top of the RV32I integer datapath: decode, execute and register file wired together
`timescale 1ns/1ps
`default_nettype none

`include "rv_int_config.svh"

module rv_int_core (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    // instruction in
    input  wire logic                  instr_valid_i,
    input  wire logic [`RV_XLEN-1:0]   instr_i,
    // retire report, two cycles after issue
    output logic                       retire_valid_o,
    output logic      [`RV_REG_AW-1:0] retire_rd_o,
    output logic      [`RV_XLEN-1:0]   retire_data_o,
    output logic                       retire_illegal_o,
    // debug register access
    input  wire logic                  dbg_we_i,
    input  wire logic [`RV_REG_AW-1:0] dbg_addr_i,
    input  wire logic [`RV_XLEN-1:0]   dbg_wdata_i,
    output logic      [`RV_XLEN-1:0]   dbg_rdata_o
);

    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    rv_int_pkg::id_ex_t    id_ex;
    rv_int_pkg::ex_wb_t    ex_fwd;
    rv_int_pkg::ex_wb_t    ex_wb;
    logic                  rf_we;

    rv_decode rv_decode_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),  // raw word onto the union
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .ex_fwd_i      (ex_fwd),
        .id_ex_o       (id_ex)
    );

    rv_execute rv_execute_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .id_ex_i  (id_ex),
        .ex_fwd_o (ex_fwd),
        .ex_wb_o  (ex_wb)
    );

    assign rf_we = ex_wb.valid && !ex_wb.illegal;  // illegal retires write nothing

    rv_regfile rv_regfile_i (
        .clk_i       (clk_i),
        .we_i        (rf_we),
        .waddr_i     (ex_wb.rd),
        .wdata_i     (ex_wb.result),
        .raddr1_i    (rs1),
        .raddr2_i    (rs2),
        .rdata1_o    (rs1_data),
        .rdata2_o    (rs2_data),
        .dbg_we_i    (dbg_we_i),
        .dbg_addr_i  (dbg_addr_i),
        .dbg_wdata_i (dbg_wdata_i),
        .dbg_rdata_o (dbg_rdata_o)
    );

    assign retire_valid_o   = ex_wb.valid;
    assign retire_rd_o      = ex_wb.rd;
    assign retire_data_o    = ex_wb.result;
    assign retire_illegal_o = ex_wb.illegal;

endmodule

`default_nettype wire

/* hw/rv_execute.sv */
// execute stage: ALU plus the ex/wb register feeding regfile write and retire outputs
`timescale 1ns/1ps
`default_nettype none

`include "rv_int_config.svh"

module rv_execute (
    input  wire logic               clk_i,
    input  wire logic               rst_n_i,
    input  wire rv_int_pkg::id_ex_t id_ex_i,
    output rv_int_pkg::ex_wb_t      ex_fwd_o,  // combinational, for decode
    output rv_int_pkg::ex_wb_t      ex_wb_o    // registered writeback record
);

    logic [`RV_XLEN-1:0]   alu_res;
    logic [`RV_XLEN-1:0]   result;
    logic [4:0]            shamt;
    logic                  valid_q;
    logic                  illegal_q;
    logic [`RV_REG_AW-1:0] rd_q;
    logic [`RV_XLEN-1:0]   result_q;

    assign shamt = id_ex_i.op_b[4:0];  // rv32 shifts use low five bits

    always_comb begin
        case (id_ex_i.op)
            rv_int_pkg::ALU_ADD:  alu_res = id_ex_i.op_a + id_ex_i.op_b;
            rv_int_pkg::ALU_SUB:  alu_res = id_ex_i.op_a - id_ex_i.op_b;
            rv_int_pkg::ALU_SLL:  alu_res = id_ex_i.op_a << shamt;
            rv_int_pkg::ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}},
                                             $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b)};
            rv_int_pkg::ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}},
                                             id_ex_i.op_a < id_ex_i.op_b};
            rv_int_pkg::ALU_XOR:  alu_res = id_ex_i.op_a ^ id_ex_i.op_b;
            rv_int_pkg::ALU_SRL:  alu_res = id_ex_i.op_a >> shamt;
            rv_int_pkg::ALU_SRA:  alu_res = $unsigned($signed(id_ex_i.op_a) >>> shamt);
            rv_int_pkg::ALU_OR:   alu_res = id_ex_i.op_a | id_ex_i.op_b;
            rv_int_pkg::ALU_AND:  alu_res = id_ex_i.op_a & id_ex_i.op_b;
            default:              alu_res = '0;
        endcase
    end

    // illegal words retire with zero data
    assign result = id_ex_i.illegal ? '0 : alu_res;

    assign ex_fwd_o = '{valid: id_ex_i.valid, illegal: id_ex_i.illegal, rd: id_ex_i.rd,
                        result: result};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q   <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            valid_q   <= id_ex_i.valid;
            illegal_q <= id_ex_i.illegal;
        end
    end

    always_ff @(posedge clk_i) begin
        if (id_ex_i.valid) begin
            rd_q     <= id_ex_i.rd;
            result_q <= result;
        end
    end

    assign ex_wb_o = '{valid: valid_q, illegal: illegal_q, rd: rd_q, result: result_q};

endmodule

`default_nettype wire

/* hw/rv_decode.sv */
// decode stage: field split, legality check, operand read with forwarding, id/ex register
`timescale 1ns/1ps
`default_nettype none

`include "rv_int_config.svh"

module rv_decode (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  instr_valid_i,  // one-cycle strobe
    input  wire rv_int_pkg::instr_u    instr_i,
    // regfile read ports, same-cycle data
    output logic      [`RV_REG_AW-1:0] rs1_o,
    output logic      [`RV_REG_AW-1:0] rs2_o,
    input  wire logic [`RV_XLEN-1:0]   rs1_data_i,
    input  wire logic [`RV_XLEN-1:0]   rs2_data_i,
    input  wire rv_int_pkg::ex_wb_t    ex_fwd_i,  // result now in execute
    output rv_int_pkg::id_ex_t         id_ex_o
);

    logic                  f7_alt;
    logic                  illegal_d;
    logic                  use_imm;
    rv_int_pkg::alu_op_e   op_d;
    logic [`RV_XLEN-1:0]   imm_sext;
    logic                  fwd_a;
    logic                  fwd_b;
    logic [`RV_XLEN-1:0]   opa_d;
    logic [`RV_XLEN-1:0]   opb_d;
    // id/ex register, control split from payload
    logic                  valid_q;
    logic                  illegal_q;
    rv_int_pkg::alu_op_e   op_q;
    logic [`RV_REG_AW-1:0] rd_q;
    logic [`RV_XLEN-1:0]   opa_q;
    logic [`RV_XLEN-1:0]   opb_q;

    assign rs1_o    = instr_i.r.rs1;
    assign rs2_o    = instr_i.r.rs2;  // don't care for the imm class
    assign f7_alt   = (instr_i.r.funct7 == rv_int_pkg::F7_ALT);  // imm[11:5] on i-type
    assign imm_sext = {{(`RV_XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};

    always_comb begin
        illegal_d = 1'b0;
        use_imm   = 1'b0;
        // base op from funct3
        case (instr_i.r.funct3)
            rv_int_pkg::F3_ADD:  op_d = rv_int_pkg::ALU_ADD;
            rv_int_pkg::F3_SLL:  op_d = rv_int_pkg::ALU_SLL;
            rv_int_pkg::F3_SLT:  op_d = rv_int_pkg::ALU_SLT;
            rv_int_pkg::F3_SLTU: op_d = rv_int_pkg::ALU_SLTU;
            rv_int_pkg::F3_XOR:  op_d = rv_int_pkg::ALU_XOR;
            rv_int_pkg::F3_SR:   op_d = f7_alt ? rv_int_pkg::ALU_SRA : rv_int_pkg::ALU_SRL;
            rv_int_pkg::F3_OR:   op_d = rv_int_pkg::ALU_OR;
            default:             op_d = rv_int_pkg::ALU_AND;
        endcase
        case (instr_i.r.opcode)
            rv_int_pkg::OPC_OP: begin
                if (f7_alt && (instr_i.r.funct3 == rv_int_pkg::F3_ADD)) begin
                    op_d = rv_int_pkg::ALU_SUB;
                end
                // only sub and sra have a non-zero funct7
                if ((instr_i.r.funct7 != rv_int_pkg::F7_ZERO) &&
                    !(f7_alt && ((instr_i.r.funct3 == rv_int_pkg::F3_ADD) ||
                                 (instr_i.r.funct3 == rv_int_pkg::F3_SR)))) begin
                    illegal_d = 1'b1;
                end
            end
            rv_int_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                // shift immediates keep imm[11:5] fixed
                if ((instr_i.i.funct3 == rv_int_pkg::F3_SLL) &&
                    (instr_i.r.funct7 != rv_int_pkg::F7_ZERO)) begin
                    illegal_d = 1'b1;
                end
                if ((instr_i.i.funct3 == rv_int_pkg::F3_SR) &&
                    (instr_i.r.funct7 != rv_int_pkg::F7_ZERO) && !f7_alt) begin
                    illegal_d = 1'b1;
                end
            end
            default: illegal_d = 1'b1;  // anything else is unsupported
        endcase
    end

    // forward from execute, never for x0
    assign fwd_a = ex_fwd_i.valid && !ex_fwd_i.illegal && (ex_fwd_i.rd != '0) &&
                   (ex_fwd_i.rd == rs1_o);
    assign fwd_b = ex_fwd_i.valid && !ex_fwd_i.illegal && (ex_fwd_i.rd != '0) &&
                   (ex_fwd_i.rd == rs2_o);
    assign opa_d = fwd_a ? ex_fwd_i.result : rs1_data_i;
    assign opb_d = use_imm ? imm_sext : (fwd_b ? ex_fwd_i.result : rs2_data_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q   <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            valid_q   <= instr_valid_i;
            illegal_q <= instr_valid_i && illegal_d;  // only flagged with valid
        end
    end

    // payload only moves on a strobe
    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            op_q  <= op_d;
            rd_q  <= instr_i.r.rd;
            opa_q <= opa_d;
            opb_q <= opb_d;
        end
    end

    assign id_ex_o = '{valid: valid_q, illegal: illegal_q, op: op_q, rd: rd_q,
                       op_a: opa_q, op_b: opb_q};

endmodule

`default_nettype wire

/* hw/rv_regfile.sv */
// general-purpose register file with write-through bypass and a debug access port
`timescale 1ns/1ps
`default_nettype none

`include "rv_int_config.svh"

module rv_regfile (
    input  wire logic                  clk_i,
    // writeback port
    input  wire logic                  we_i,
    input  wire logic [`RV_REG_AW-1:0] waddr_i,
    input  wire logic [`RV_XLEN-1:0]   wdata_i,
    // operand reads for decode
    input  wire logic [`RV_REG_AW-1:0] raddr1_i,
    input  wire logic [`RV_REG_AW-1:0] raddr2_i,
    output logic      [`RV_XLEN-1:0]   rdata1_o,
    output logic      [`RV_XLEN-1:0]   rdata2_o,
    // debug access
    input  wire logic                  dbg_we_i,
    input  wire logic [`RV_REG_AW-1:0] dbg_addr_i,
    input  wire logic [`RV_XLEN-1:0]   dbg_wdata_i,
    output logic      [`RV_XLEN-1:0]   dbg_rdata_o
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_NUM];  // contents undefined until written

    // operand read, x0 first, then bypass of the current writeback
    function automatic logic [`RV_XLEN-1:0] op_read(input logic [`RV_REG_AW-1:0] addr);
        logic [`RV_XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (we_i && (addr == waddr_i)) begin
            val = wdata_i;  // result from two instructions back
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    // writeback beats debug, x0 never written
    always_ff @(posedge clk_i) begin
        if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end else if (dbg_we_i && (dbg_addr_i != '0)) begin
            regs[dbg_addr_i] <= dbg_wdata_i;  // dropped on a writeback cycle
        end
    end

    always_comb begin
        rdata1_o = op_read(raddr1_i);
        rdata2_o = op_read(raddr2_i);
    end

    // debug view is the stored value only, no bypass
    assign dbg_rdata_o = (dbg_addr_i == '0) ? '0 : regs[dbg_addr_i];

endmodule

`default_nettype wire

/* hw/rv_int_pkg.sv */
// shared types for the RV32I integer datapath, referenced by scoped name from each stage
`default_nettype none

`include "rv_int_config.svh"

package rv_int_pkg;

    // major opcodes handled by this datapath
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // register-immediate

    // funct3 map, same for both classes
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // srl/sra, split by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_ZERO = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra, srai

    // register-register layout
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } r_instr_t;

    // register-immediate layout
    typedef struct packed {
        logic [11:0]           imm12;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } i_instr_t;

    // one instruction word, two views
    typedef union packed {
        r_instr_t r;
        i_instr_t i;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // decode -> execute
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        alu_op_e               op;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   op_a;
        logic [`RV_XLEN-1:0]   op_b;  // rs2 value or sign-extended imm
    } id_ex_t;

    // execute -> writeback, also the forward record
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   result;
    } ex_wb_t;

endpackage

`default_nettype wire

/* hw/rv_int_config.svh */
// integer core sizing macros, included by the RTL, the package and the testbench
`ifndef RV_INT_CONFIG_SVH
`define RV_INT_CONFIG_SVH

// data path and register width
`define RV_XLEN 32

// architectural register count, x0 included
`define RV_REG_NUM 32

// bits needed to name one register
`define RV_REG_AW 5

`endif
